// ==== eth_loop_pkg.sv ====
// Stream word types, frame counter type and frame FIFO write state enum
`default_nettype none

package eth_loop_pkg;

    // MAC stream width at 64 bits per beat
    localparam int STREAM_DATA_W = 64;

    // One byte enable per data byte
    localparam int STREAM_KEEP_W = STREAM_DATA_W / 8;

    // Frame statistics width
    localparam int FRAME_CNT_W = 32;

    // Data word of one stream beat
    typedef logic [STREAM_DATA_W-1:0] stream_data_t;

    // Byte enables of one stream beat
    typedef logic [STREAM_KEEP_W-1:0] stream_keep_t;

    // Good or dropped frame count
    typedef logic [FRAME_CNT_W-1:0] frame_cnt_t;

    // Write side of the frame FIFO
    // idle waits for the first beat of a frame
    // store holds a frame that is being written
    // discard skips the tail of a frame that is already dropped
    typedef enum logic [1:0] {
        idle,
        store,
        discard
    } fifo_state_t;

endpackage

`default_nettype wire

// ==== frame_fifo.sv ====
// Synchronous frame FIFO with commit or rollback at frame end and drop of bad, long or full frames
`default_nettype none

module frame_fifo
    import eth_loop_pkg::*;
#(
    parameter int FIFO_DEPTH      = 64,
    parameter int MAX_FRAME_BEATS = 24
)
(
    input  wire logic         clk_125mhz,
    input  wire logic         reset,

    // Receive stream from the MAC, no back-pressure
    input  wire stream_data_t rx_data,
    input  wire stream_keep_t rx_keep,
    input  wire logic         rx_valid,
    input  wire logic         rx_last,
    input  wire logic         rx_user,

    // Transmit stream
    output wire stream_data_t tx_data,
    output wire stream_keep_t tx_keep,
    output wire logic         tx_valid,
    output wire logic         tx_last,
    input  wire logic         tx_ready,

    // Frame end status pulses
    output logic              frame_good,
    output logic              frame_drop
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    // Extra bit tells a full FIFO from an empty one
    localparam int PTR_W  = ADDR_W + 1;
    // Enough to count one beat past the limit
    localparam int BEAT_W = $clog2(MAX_FRAME_BEATS + 2);

    // Storage for data, keep and last of each word
    stream_data_t mem_data [FIFO_DEPTH];
    stream_keep_t mem_keep [FIFO_DEPTH];
    logic         mem_last [FIFO_DEPTH];

    // Write, commit and read pointers
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  commit_ptr;
    logic [PTR_W-1:0]  rd_ptr;

    // Write side state
    fifo_state_t       state;
    logic [BEAT_W-1:0] beat_cnt;

    logic [PTR_W-1:0]  used_words;
    logic [BEAT_W-1:0] frame_beats;
    logic              fifo_full;
    logic              too_long;
    logic              mem_we;
    logic              tx_xfer;

    // Partial frame words count as used
    assign used_words = wr_ptr - rd_ptr;
    assign fifo_full  = used_words == PTR_W'(FIFO_DEPTH);

    // Length of the current frame including the beat on the bus
    assign frame_beats = (state == store) ? beat_cnt + 1'b1 : BEAT_W'(1);
    assign too_long    = frame_beats > BEAT_W'(MAX_FRAME_BEATS);

    assign mem_we = rx_valid && (state != discard) && !fifo_full && !too_long;

    always_ff @(posedge clk_125mhz) begin
        if (mem_we) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= rx_data;
            mem_keep[wr_ptr[ADDR_W-1:0]] <= rx_keep;
            mem_last[wr_ptr[ADDR_W-1:0]] <= rx_last;
        end
    end

    // Write side FSM with commit and rollback
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            state      <= idle;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            beat_cnt   <= '0;
            frame_good <= 1'b0;
            frame_drop <= 1'b0;
        end else begin
            frame_good <= 1'b0;
            frame_drop <= 1'b0;

            if (rx_valid) begin
                case (state)
                    idle, store: begin
                        if (mem_we) begin
                            if (rx_last) begin
                                state    <= idle;
                                beat_cnt <= '0;
                                if (rx_user) begin
                                    // Bad frame, forget everything since the last commit
                                    wr_ptr     <= commit_ptr;
                                    frame_drop <= 1'b1;
                                end else begin
                                    wr_ptr     <= wr_ptr + 1'b1;
                                    commit_ptr <= wr_ptr + 1'b1;
                                    frame_good <= 1'b1;
                                end
                            end else begin
                                state    <= store;
                                wr_ptr   <= wr_ptr + 1'b1;
                                beat_cnt <= frame_beats;
                            end
                        end else begin
                            // Oversize or no room left
                            wr_ptr   <= commit_ptr;
                            beat_cnt <= '0;
                            if (rx_last) begin
                                state      <= idle;
                                frame_drop <= 1'b1;
                            end else begin
                                state <= discard;
                            end
                        end
                    end

                    discard: begin
                        // Skip the rest of the frame
                        if (rx_last) begin
                            state      <= idle;
                            frame_drop <= 1'b1;
                        end
                    end

                    default: begin
                        state    <= idle;
                        wr_ptr   <= commit_ptr;
                        beat_cnt <= '0;
                    end
                endcase
            end
        end
    end

    // Read side only sees committed words
    assign tx_valid = rd_ptr != commit_ptr;
    assign tx_data  = mem_data[rd_ptr[ADDR_W-1:0]];
    assign tx_keep  = mem_keep[rd_ptr[ADDR_W-1:0]];
    assign tx_last  = mem_last[rd_ptr[ADDR_W-1:0]];

    assign tx_xfer = tx_valid && tx_ready;

    // Word under rd_ptr is never rewritten while it waits
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (tx_xfer) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== loop_status.sv ====
// Per-channel good and drop frame counters with link and drop LED drivers
`default_nettype none

module loop_status
    import eth_loop_pkg::*;
#(
    parameter int CH_COUNT = 2,
    parameter int LED_HOLD = 16
)
(
    input  wire logic                  clk_125mhz,
    input  wire logic                  reset,

    // Frame end pulses from the FIFOs
    input  wire logic [CH_COUNT-1:0]   frame_good,
    input  wire logic [CH_COUNT-1:0]   frame_drop,

    // Link status per channel
    input  wire logic [CH_COUNT-1:0]   rx_status,

    // Statistics
    output frame_cnt_t [CH_COUNT-1:0]  good_count,
    output frame_cnt_t [CH_COUNT-1:0]  drop_count,

    // Board LEDs
    output logic [CH_COUNT-1:0]        led_green,
    output logic [CH_COUNT-1:0]        led_orange
);

    localparam int HOLD_W = $clog2(LED_HOLD + 1);

    // Orange stretch timers
    logic [HOLD_W-1:0] hold_cnt [CH_COUNT];

    // Frame counters stop at all ones
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            good_count <= '0;
            drop_count <= '0;
        end else begin
            for (int i = 0; i < CH_COUNT; i++) begin
                if (frame_good[i] && good_count[i] != '1) begin
                    good_count[i] <= good_count[i] + 1'b1;
                end
                if (frame_drop[i] && drop_count[i] != '1) begin
                    drop_count[i] <= drop_count[i] + 1'b1;
                end
            end
        end
    end

    // Each drop restarts the stretch
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            for (int i = 0; i < CH_COUNT; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CH_COUNT; i++) begin
                if (frame_drop[i]) begin
                    hold_cnt[i] <= HOLD_W'(LED_HOLD);
                end else if (hold_cnt[i] != '0) begin
                    hold_cnt[i] <= hold_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < CH_COUNT; i++) begin
            led_orange[i] = hold_cnt[i] != '0;
        end
    end

    // Link LED one register behind rx_status
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            led_green <= '0;
        end else begin
            led_green <= rx_status;
        end
    end

endmodule

`default_nettype wire

// ==== eth_loop_core.sv ====
// Top level with one frame FIFO per channel looped back and the status block
`default_nettype none

module eth_loop_core
    import eth_loop_pkg::*;
#(
    parameter int CH_COUNT        = 2,
    parameter int FIFO_DEPTH      = 64,
    parameter int MAX_FRAME_BEATS = 24,
    parameter int LED_HOLD        = 16
)
(
    // Single 125 MHz clock with synchronous reset
    input  wire logic                         clk_125mhz,
    input  wire logic                         reset,

    // Receive streams from the MACs
    input  wire stream_data_t [CH_COUNT-1:0]  rx_data,
    input  wire stream_keep_t [CH_COUNT-1:0]  rx_keep,
    input  wire logic [CH_COUNT-1:0]          rx_valid,
    input  wire logic [CH_COUNT-1:0]          rx_last,
    input  wire logic [CH_COUNT-1:0]          rx_user,
    input  wire logic [CH_COUNT-1:0]          rx_status,

    // Transmit streams to the MACs
    output wire stream_data_t [CH_COUNT-1:0]  tx_data,
    output wire stream_keep_t [CH_COUNT-1:0]  tx_keep,
    output wire logic [CH_COUNT-1:0]          tx_valid,
    output wire logic [CH_COUNT-1:0]          tx_last,
    input  wire logic [CH_COUNT-1:0]          tx_ready,

    // Statistics
    output wire frame_cnt_t [CH_COUNT-1:0]    good_count,
    output wire frame_cnt_t [CH_COUNT-1:0]    drop_count,

    // LEDs
    output wire logic [CH_COUNT-1:0]          led_green,
    output wire logic [CH_COUNT-1:0]          led_orange
);

    wire [CH_COUNT-1:0] frame_good;
    wire [CH_COUNT-1:0] frame_drop;

    // Each channel loops back to itself
    for (genvar n = 0; n < CH_COUNT; n = n + 1) begin : ch

        frame_fifo #(
            .FIFO_DEPTH      (FIFO_DEPTH),
            .MAX_FRAME_BEATS (MAX_FRAME_BEATS)
        )
        ch_fifo (
            .clk_125mhz (clk_125mhz),
            .reset      (reset),

            .rx_data    (rx_data[n]),
            .rx_keep    (rx_keep[n]),
            .rx_valid   (rx_valid[n]),
            .rx_last    (rx_last[n]),
            .rx_user    (rx_user[n]),

            .tx_data    (tx_data[n]),
            .tx_keep    (tx_keep[n]),
            .tx_valid   (tx_valid[n]),
            .tx_last    (tx_last[n]),
            .tx_ready   (tx_ready[n]),

            .frame_good (frame_good[n]),
            .frame_drop (frame_drop[n])
        );

    end

    loop_status #(
        .CH_COUNT (CH_COUNT),
        .LED_HOLD (LED_HOLD)
    )
    status_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .frame_good (frame_good),
        .frame_drop (frame_drop),
        .rx_status  (rx_status),
        .good_count (good_count),
        .drop_count (drop_count),
        .led_green  (led_green),
        .led_orange (led_orange)
    );

endmodule

`default_nettype wire

// ==== tb_eth_loop_model.svh ====
// Xorshift generator, frame stimulus, reference model queues and typed compare tasks
`ifndef TB_ETH_LOOP_MODEL_SVH
`define TB_ETH_LOOP_MODEL_SVH

logic [31:0] rng_state = 32'd92911;

// Committed words that the DUT still has to send, per channel
stream_data_t exp_data [CH_COUNT][$];
stream_keep_t exp_keep [CH_COUNT][$];
logic         exp_last [CH_COUNT][$];
frame_cnt_t   exp_good [CH_COUNT];
frame_cnt_t   exp_drop [CH_COUNT];

function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic int rand_range(input int lo, input int hi);
    logic [31:0] span;
    span = 32'(hi - lo + 1);
    return lo + int'(xorshift32() % span);
endfunction

task automatic compare_data(input string name, input stream_data_t exp, input stream_data_t act);
    if (exp !== act) begin
        fail_now($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic compare_keep(input string name, input stream_keep_t exp, input stream_keep_t act);
    if (exp !== act) begin
        fail_now($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic compare_count(input string name, input frame_cnt_t exp, input frame_cnt_t act);
    if (exp !== act) begin
        fail_now($sformatf("[ERROR] %s expected %0d actual %0d", name, exp, act));
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        fail_now($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
    end
endtask

// Drives one frame and applies the drop rules to the model
task automatic send_frame(input int ch, input int len, input logic bad, output logic dropped);
    stream_data_t fd [$];
    stream_keep_t fk [$];
    stream_data_t d;
    stream_keep_t k;
    logic         last;
    int           i;
    int           gap;
    dropped = bad || (len > MAX_FRAME_BEATS) || (exp_data[ch].size() + len > FIFO_DEPTH);
    for (i = 0; i < len; i++) begin
        gap = rand_range(0, 2);
        repeat (gap) begin
            @(posedge clk_125mhz);
            rx_valid[ch] <= 1'b0;
        end
        last = (i == len - 1);
        d = {xorshift32(), xorshift32()};
        k = last ? stream_keep_t'(8'hff >> rand_range(0, 7)) : '1;
        @(posedge clk_125mhz);
        rx_data[ch]  <= d;
        rx_keep[ch]  <= k;
        rx_valid[ch] <= 1'b1;
        rx_last[ch]  <= last;
        // User flag only counts on the last beat
        rx_user[ch]  <= last ? bad : (rand_range(0, 1) == 1);
        fd.push_back(d);
        fk.push_back(k);
    end
    @(posedge clk_125mhz);
    rx_valid[ch] <= 1'b0;
    rx_last[ch]  <= 1'b0;
    rx_user[ch]  <= 1'b0;
    if (dropped) begin
        exp_drop[ch] = exp_drop[ch] + 32'd1;
    end else begin
        exp_good[ch] = exp_good[ch] + 32'd1;
        for (i = 0; i < len; i++) begin
            exp_data[ch].push_back(fd[i]);
            exp_keep[ch].push_back(fk[i]);
            exp_last[ch].push_back(i == len - 1);
        end
    end
endtask

`endif

// ==== tb_eth_loop_core.sv ====
// Testbench top with clock, reset, stimulus phases, output monitor and checks
`default_nettype none

module tb_eth_loop_core
    import eth_loop_pkg::*;
;

    localparam int CH_COUNT        = 2;
    localparam int FIFO_DEPTH      = 64;
    localparam int MAX_FRAME_BEATS = 24;
    localparam int LED_HOLD        = 16;
    localparam int WAIT_LIMIT      = 4000;

    logic                         clk_125mhz;
    logic                         reset;
    stream_data_t [CH_COUNT-1:0]  rx_data;
    stream_keep_t [CH_COUNT-1:0]  rx_keep;
    logic [CH_COUNT-1:0]          rx_valid;
    logic [CH_COUNT-1:0]          rx_last;
    logic [CH_COUNT-1:0]          rx_user;
    logic [CH_COUNT-1:0]          rx_status;
    stream_data_t [CH_COUNT-1:0]  tx_data;
    stream_keep_t [CH_COUNT-1:0]  tx_keep;
    logic [CH_COUNT-1:0]          tx_valid;
    logic [CH_COUNT-1:0]          tx_last;
    logic [CH_COUNT-1:0]          tx_ready;
    frame_cnt_t [CH_COUNT-1:0]    good_count;
    frame_cnt_t [CH_COUNT-1:0]    drop_count;
    logic [CH_COUNT-1:0]          led_green;
    logic [CH_COUNT-1:0]          led_orange;

    // 0 holds tx_ready low, 1 randomizes it, 2 holds it high
    int ready_mode;

    `include "tb_eth_loop_model.svh"

    eth_loop_core eth_loop_core_i (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_keep    (rx_keep),
        .rx_valid   (rx_valid),
        .rx_last    (rx_last),
        .rx_user    (rx_user),
        .rx_status  (rx_status),
        .tx_data    (tx_data),
        .tx_keep    (tx_keep),
        .tx_valid   (tx_valid),
        .tx_last    (tx_last),
        .tx_ready   (tx_ready),
        .good_count (good_count),
        .drop_count (drop_count),
        .led_green  (led_green),
        .led_orange (led_orange)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        clk_125mhz = 1'b0;
        forever #20 clk_125mhz = ~clk_125mhz;
    end

    always @(posedge clk_125mhz) begin
        case (ready_mode)
            0:       tx_ready <= '0;
            1:       tx_ready <= CH_COUNT'(xorshift32());
            default: tx_ready <= '1;
        endcase
    end

    // Beats seen at the falling edge transfer on the next rising edge
    always @(negedge clk_125mhz) begin
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            if (!reset && tx_valid[ch] && tx_ready[ch]) begin
                if (exp_data[ch].size() == 0) begin
                    fail_now($sformatf("Channel %0d sent a beat that was not expected", ch));
                end else begin
                    compare_data($sformatf("loopback data ch%0d", ch),
                                 exp_data[ch][0], tx_data[ch]);
                    compare_keep($sformatf("loopback keep ch%0d", ch),
                                 exp_keep[ch][0], tx_keep[ch]);
                    compare_bit($sformatf("loopback last ch%0d", ch),
                                exp_last[ch][0], tx_last[ch]);
                    void'(exp_data[ch].pop_front());
                    void'(exp_keep[ch].pop_front());
                    void'(exp_last[ch].pop_front());
                end
            end
        end
    end

    task automatic wait_room(input int ch, input int len);
        int n;
        n = 0;
        while (exp_data[ch].size() + len > FIFO_DEPTH) begin
            @(negedge clk_125mhz);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_now($sformatf("Channel %0d never freed room for the next frame", ch));
            end
        end
    endtask

    // Drains the channel and checks both counters
    task automatic check_counts(input int ch, input string name);
        int n;
        n = 0;
        while (exp_data[ch].size() != 0) begin
            @(negedge clk_125mhz);
            n++;
            if (n > WAIT_LIMIT) begin
                fail_now($sformatf("Channel %0d did not send all expected frames", ch));
            end
        end
        repeat (3) @(negedge clk_125mhz);
        compare_count({name, " good_count"}, exp_good[ch], good_count[ch]);
        compare_count({name, " drop_count"}, exp_drop[ch], drop_count[ch]);
    endtask

    initial begin
        logic dropped;
        logic seen_high;
        int   len;
        int   n;
        reset      <= 1'b1;
        rx_data    <= '0;
        rx_keep    <= '0;
        rx_valid   <= '0;
        rx_last    <= '0;
        rx_user    <= '0;
        rx_status  <= '0;
        tx_ready   <= '0;
        ready_mode = 0;
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            exp_good[ch] = '0;
            exp_drop[ch] = '0;
        end
        repeat (3) @(posedge clk_125mhz);
        reset <= 1'b0;

        @(negedge clk_125mhz);
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            compare_bit("reset tx_valid", 1'b0, tx_valid[ch]);
            compare_bit("reset led_green", 1'b0, led_green[ch]);
            compare_bit("reset led_orange", 1'b0, led_orange[ch]);
            compare_count("reset good_count", '0, good_count[ch]);
            compare_count("reset drop_count", '0, drop_count[ch]);
        end

        // Good frames with random back-pressure
        ready_mode = 1;
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            for (int f = 0; f < 20; f++) begin
                len = rand_range(1, MAX_FRAME_BEATS);
                wait_room(ch, len);
                send_frame(ch, len, 1'b0, dropped);
            end
            check_counts(ch, "loopback");
        end

        // Mix of bad, oversize and good frames
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            for (int f = 0; f < 24; f++) begin
                len = rand_range(1, 30);
                wait_room(ch, len);
                send_frame(ch, len, rand_range(0, 3) == 0, dropped);
            end
            check_counts(ch, "drops");
        end

        // Fill with the output stalled, then drain
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            ready_mode = 0;
            repeat (2) @(negedge clk_125mhz);
            dropped = 1'b0;
            n = 0;
            while (!dropped) begin
                len = rand_range(4, MAX_FRAME_BEATS);
                send_frame(ch, len, 1'b0, dropped);
                n++;
                if (n > 40) begin
                    fail_now("Stalled FIFO never reached the full drop");
                end
            end
            ready_mode = 2;
            check_counts(ch, "full");
        end

        // Link LEDs follow rx_status
        for (int i = 0; i < 6; i++) begin
            @(posedge clk_125mhz);
            rx_status <= CH_COUNT'(xorshift32());
            repeat (2) @(posedge clk_125mhz);
            @(negedge clk_125mhz);
            for (int ch = 0; ch < CH_COUNT; ch++) begin
                compare_bit("led_green", rx_status[ch], led_green[ch]);
            end
        end

        // Drop LED stretch
        n = 0;
        while (led_orange[0]) begin
            @(negedge clk_125mhz);
            n++;
            if (n > LED_HOLD + 5) begin
                fail_now("Orange LED stayed on with no recent drop");
            end
        end
        send_frame(0, 3, 1'b1, dropped);
        seen_high = 1'b0;
        for (int c = 1; c <= LED_HOLD + 3; c++) begin
            @(negedge clk_125mhz);
            if (c <= 3 && led_orange[0]) begin
                seen_high = 1'b1;
            end
        end
        compare_bit("led_orange after drop", 1'b1, seen_high);
        compare_bit("led_orange after hold", 1'b0, led_orange[0]);
        check_counts(0, "led");

        $display("Regression passed");
        $finish;
    end

    // Overall limit on the run
    initial begin
        #4000000;
        $display("Simulation ran past its time limit");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
eth_loop_pkg.sv
frame_fifo.sv
loop_status.sv
eth_loop_core.sv
tb_eth_loop_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator, then check the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_eth_loop_core -f project.f -o sim_eth_loop \
    > sim.log 2>&1 &&
./obj_dir/sim_eth_loop >> sim.log 2>&1 ||
echo "Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
